// ==== sata_prim_pkg.sv ====
package sata_prim_pkg;

    // Request kinds from the transport layer
    typedef enum logic [3:0] {
        DATA,                                 // Frame payload, scrambled
        CRC,                                  // Frame CRC, scrambled like data
        SOF,
        EOF,
        HOLD,
        HOLDA,
        R_RDY,
        X_RDY,
        WTRM,
        R_IP,
        R_OK,
        R_ERR,
        SYNC,
        DMAT
    } prim_kind_t;

    // Primitive dwords, K28 always sits in byte 0
    localparam logic [31:0] ALIGN_P = 32'h7B4A_4ABC;
    localparam logic [31:0] CONT_P  = 32'h9999_AA7C;
    localparam logic [31:0] SYNC_P  = 32'hB5B5_957C;
    localparam logic [31:0] HOLD_P  = 32'hD5D5_AA7C;
    localparam logic [31:0] HOLDA_P = 32'h9595_AA7C;
    localparam logic [31:0] R_RDY_P = 32'h4A4A_957C;
    localparam logic [31:0] X_RDY_P = 32'h5757_B57C;
    localparam logic [31:0] SOF_P   = 32'h3737_B57C;
    localparam logic [31:0] EOF_P   = 32'hD5D5_B57C;
    localparam logic [31:0] WTRM_P  = 32'h5858_B57C;
    localparam logic [31:0] R_IP_P  = 32'h5555_B57C;
    localparam logic [31:0] R_OK_P  = 32'h3535_B57C;
    localparam logic [31:0] R_ERR_P = 32'h5656_B57C;
    localparam logic [31:0] DMAT_P  = 32'h3636_B57C;

    localparam logic [3:0] K_PRIM = 4'b0001; // K28 in the low byte
    localparam logic [3:0] K_DATA = 4'b0000; // Plain data characters

    // Code of a primitive kind, data kinds fall back to SYNC and are never sent so
    function automatic logic [31:0] prim_code(input prim_kind_t kind);
        case (kind)
            SOF:     return SOF_P;
            EOF:     return EOF_P;
            HOLD:    return HOLD_P;
            HOLDA:   return HOLDA_P;
            R_RDY:   return R_RDY_P;
            X_RDY:   return X_RDY_P;
            WTRM:    return WTRM_P;
            R_IP:    return R_IP_P;
            R_OK:    return R_OK_P;
            R_ERR:   return R_ERR_P;
            DMAT:    return DMAT_P;
            default: return SYNC_P;
        endcase
    endfunction

    function automatic logic is_data(input prim_kind_t kind);
        return (kind == DATA) || (kind == CRC); // Payload words of a frame
    endfunction

    // Frame delimiters and DMAT are one-shot, everything else may be continued
    function automatic logic is_repeatable(input prim_kind_t kind);
        return !is_data(kind) && (kind != SOF) && (kind != EOF) && (kind != DMAT);
    endfunction

endpackage

// ==== sata_link_pkg.sv ====
package sata_link_pkg;

    localparam int DWORD_W = 32; // Link word width

    // ALIGN pacing
    localparam int ALIGN_CNT_W = 8;                                // Counter wraps at 256
    localparam logic [ALIGN_CNT_W-1:0] ALIGN_SLOT0 = 8'd252;      // First pause count
    localparam logic [ALIGN_CNT_W-1:0] ALIGN_SLOT1 = 8'd253;      // Second pause count

    // Scrambler
    localparam logic [DWORD_W-1:0] LFSR_POLY = 32'h04C1_1DB7;     // Galois taps
    localparam logic [DWORD_W-1:0] LFSR_SEED = 32'hC2D2_768D;     // Value after reset and SOF

    // Continuation run
    localparam int RUN_W = 2;                                      // Saturating position
    localparam logic [RUN_W-1:0] RUN_CONT = 2'd3;                  // Position replaced by CONT

    // Tracker action codes towards the selector
    localparam int ACT_W = 2;
    localparam logic [ACT_W-1:0] ACT_PASS = 2'd0;                  // Send the primitive itself
    localparam logic [ACT_W-1:0] ACT_CONT = 2'd1;                  // Send CONT
    localparam logic [ACT_W-1:0] ACT_JUNK = 2'd2;                  // Send a junk word

endpackage

// ==== scrambler_lfsr.sv ====
`timescale 1ns/10ps

module scrambler_lfsr (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              restart_i,    // Load the seed
    input  logic                              advance_i,    // Step one full word
    output logic [sata_link_pkg::DWORD_W-1:0] word_o        // Current scrambler word
);

    logic [sata_link_pkg::DWORD_W-1:0] state;

    // One word = DWORD_W serial steps of a left-shifting Galois LFSR
    function automatic logic [sata_link_pkg::DWORD_W-1:0] next_word(
        input logic [sata_link_pkg::DWORD_W-1:0] cur
    );
        logic [sata_link_pkg::DWORD_W-1:0] s;
        s = cur;
        for (int i = 0; i < sata_link_pkg::DWORD_W; i++) begin
            if (s[sata_link_pkg::DWORD_W-1])
                s = (s << 1) ^ sata_link_pkg::LFSR_POLY; // MSB out feeds the taps
            else
                s = s << 1;
        end
        return s;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= sata_link_pkg::LFSR_SEED;
        else if (restart_i)                               // Restart wins over advance
            state <= sata_link_pkg::LFSR_SEED;
        else if (advance_i)
            state <= next_word(state);
    end

    assign word_o = state;

    // Callers never ask for both in one cycle
    a_restart_xor_advance: assert property (@(posedge clk) disable iff (!rst_n)
        !(restart_i && advance_i))
        else $error("LFSR restart and advance in the same cycle");

endmodule

// ==== data_scrambler.sv ====
`timescale 1ns/10ps

module data_scrambler (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              take_i,      // Request accepted this cycle
    input  sata_prim_pkg::prim_kind_t         tx_kind_i,
    input  logic [sata_link_pkg::DWORD_W-1:0] tx_dat_i,
    output logic [sata_link_pkg::DWORD_W-1:0] scr_dat_o    // Payload XOR scrambler word
);

    logic                              take_sof;   // Accepted SOF
    logic                              take_body;  // Accepted DATA or CRC
    logic [sata_link_pkg::DWORD_W-1:0] lfsr_word;
    logic                              sof_seen;   // A frame has been opened since reset

    assign take_sof  = take_i && (tx_kind_i == sata_prim_pkg::SOF);
    assign take_body = take_i && sata_prim_pkg::is_data(tx_kind_i);

    scrambler_lfsr u_lfsr (
        .clk       (clk),
        .rst_n     (rst_n),
        .restart_i (take_sof),      // Each frame starts from the seed
        .advance_i (take_body),     // Step once per scrambled word
        .word_o    (lfsr_word)
    );

    // Word before the advance, the step lands at the edge ending the take
    assign scr_dat_o = tx_dat_i ^ lfsr_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sof_seen <= 1'b0;
        else if (take_sof)
            sof_seen <= 1'b1;
    end

    // Body words only make sense inside a frame
    a_body_after_sof: assert property (@(posedge clk) disable iff (!rst_n)
        take_body |-> sof_seen)
        else $error("DATA or CRC taken before any SOF");

endmodule

// ==== prim_repeat_tracker.sv ====
`timescale 1ns/10ps

module prim_repeat_tracker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              take_i,      // Request accepted this cycle
    input  sata_prim_pkg::prim_kind_t         tx_kind_i,
    output logic [sata_link_pkg::ACT_W-1:0]   act_o,       // Pass, CONT or junk
    output logic [sata_link_pkg::DWORD_W-1:0] junk_o       // Filler word after CONT
);

    sata_prim_pkg::prim_kind_t         last_kind;  // Kind of the previous take
    logic [sata_link_pkg::RUN_W-1:0]   run_pos;    // Position of the previous take in its run
    logic [sata_link_pkg::RUN_W-1:0]   run_nxt;    // Position this request would get
    logic                              same_prim;  // Request continues the run
    logic                              take_junk;

    assign same_prim = sata_prim_pkg::is_repeatable(tx_kind_i) && (tx_kind_i == last_kind);

    // Saturating run position
    always_comb begin
        if (!same_prim)
            run_nxt = sata_link_pkg::RUN_W'(1);                 // New run
        else if (run_pos == sata_link_pkg::RUN_CONT)
            run_nxt = run_pos;                                   // Stays at 3 or more
        else
            run_nxt = run_pos + 1'b1;
    end

    always_comb begin
        if (run_nxt != sata_link_pkg::RUN_CONT)
            act_o = sata_link_pkg::ACT_PASS;                     // Positions 1 and 2
        else if (run_pos != sata_link_pkg::RUN_CONT)
            act_o = sata_link_pkg::ACT_CONT;                     // First step into 3
        else
            act_o = sata_link_pkg::ACT_JUNK;                     // Rest of the run
    end

    // Only taken requests move the run, ALIGN cycles leave it alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_kind <= sata_prim_pkg::DATA;                    // Matches no primitive
            run_pos   <= '0;
        end else if (take_i) begin
            last_kind <= tx_kind_i;
            run_pos   <= run_nxt;
        end
    end

    assign take_junk = take_i && (act_o == sata_link_pkg::ACT_JUNK);

    scrambler_lfsr u_junk_lfsr (
        .clk       (clk),
        .rst_n     (rst_n),
        .restart_i (1'b0),          // Junk stream never restarts
        .advance_i (take_junk),     // New junk only when one is sent
        .word_o    (junk_o)
    );

    // CONT follows two takes of the same repeatable kind
    a_cont_repeatable: assert property (@(posedge clk) disable iff (!rst_n)
        (take_i && act_o == sata_link_pkg::ACT_CONT)
            |-> sata_prim_pkg::is_repeatable(tx_kind_i) && (tx_kind_i == last_kind))
        else $error("CONT chosen for a kind that cannot be continued");

endmodule

// ==== link_tx_mux.sv ====
`timescale 1ns/10ps

module link_tx_mux (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              phy_rdy_i,
    input  logic                              tx_req_i,
    input  sata_prim_pkg::prim_kind_t         tx_kind_i,
    input  logic [sata_link_pkg::DWORD_W-1:0] scr_dat_i,   // From the data scrambler
    input  logic [sata_link_pkg::ACT_W-1:0]   act_i,       // From the repeat tracker
    input  logic [sata_link_pkg::DWORD_W-1:0] junk_i,
    output logic                              take_o,      // Handshake fires
    output logic                              tx_ready_o,
    output logic [sata_link_pkg::DWORD_W-1:0] tx_dat_o,
    output logic [3:0]                        tx_char_o
);

    logic [sata_link_pkg::ALIGN_CNT_W-1:0] align_cnt;  // Cycles since PHY ready, mod 256
    logic                                  pause;      // ALIGN slot, no takes
    logic [sata_link_pkg::DWORD_W-1:0]     dat_nxt;
    logic [3:0]                            char_nxt;

    // Free count while PHY is up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            align_cnt <= '0;
        else if (phy_rdy_i)
            align_cnt <= align_cnt + 1'b1;                  // Wraps at 256
        else
            align_cnt <= '0;
    end

    assign pause = (align_cnt == sata_link_pkg::ALIGN_SLOT0) ||
                   (align_cnt == sata_link_pkg::ALIGN_SLOT1);

    assign tx_ready_o = phy_rdy_i && !pause;
    assign take_o     = tx_req_i && tx_ready_o;

    // Priority: taken request, then ALIGN, then SYNC
    always_comb begin
        if (take_o) begin
            if (sata_prim_pkg::is_data(tx_kind_i)) begin
                dat_nxt  = scr_dat_i;                        // Scrambled payload
                char_nxt = sata_prim_pkg::K_DATA;
            end else begin
                case (act_i)
                    sata_link_pkg::ACT_CONT: begin
                        dat_nxt  = sata_prim_pkg::CONT_P;
                        char_nxt = sata_prim_pkg::K_PRIM;
                    end
                    sata_link_pkg::ACT_JUNK: begin
                        dat_nxt  = junk_i;                   // Looks like data on the wire
                        char_nxt = sata_prim_pkg::K_DATA;
                    end
                    default: begin
                        dat_nxt  = sata_prim_pkg::prim_code(tx_kind_i);
                        char_nxt = sata_prim_pkg::K_PRIM;
                    end
                endcase
            end
        end else if (pause) begin
            dat_nxt  = sata_prim_pkg::ALIGN_P;
            char_nxt = sata_prim_pkg::K_PRIM;
        end else begin
            dat_nxt  = sata_prim_pkg::SYNC_P;                // Idle fill
            char_nxt = sata_prim_pkg::K_PRIM;
        end
    end

    // One cycle to the PHY
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_dat_o  <= sata_prim_pkg::SYNC_P;
            tx_char_o <= sata_prim_pkg::K_PRIM;
        end else begin
            tx_dat_o  <= dat_nxt;
            tx_char_o <= char_nxt;
        end
    end

    // Ready stays low over both counts of the pause
    a_pause_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (align_cnt == sata_link_pkg::ALIGN_SLOT0) |-> !tx_ready_o ##1 !tx_ready_o)
        else $error("Ready high during an ALIGN slot");

endmodule

// ==== sata_link_tx.sv ====
`timescale 1ns/10ps

module sata_link_tx (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              phy_rdy_i,   // PHY link is up
    input  logic                              tx_req_i,
    input  sata_prim_pkg::prim_kind_t         tx_kind_i,
    input  logic [sata_link_pkg::DWORD_W-1:0] tx_dat_i,
    output logic                              tx_ready_o,  // Low during ALIGN slots
    output logic [sata_link_pkg::DWORD_W-1:0] tx_dat_o,    // Word to the PHY
    output logic [3:0]                        tx_char_o    // K mask of that word
);

    logic                              take;
    logic [sata_link_pkg::DWORD_W-1:0] scr_dat;
    logic [sata_link_pkg::ACT_W-1:0]   act;
    logic [sata_link_pkg::DWORD_W-1:0] junk;

    data_scrambler u_data_scrambler (
        .clk       (clk),
        .rst_n     (rst_n),
        .take_i    (take),
        .tx_kind_i (tx_kind_i),
        .tx_dat_i  (tx_dat_i),
        .scr_dat_o (scr_dat)
    );

    prim_repeat_tracker u_repeat_tracker (
        .clk       (clk),
        .rst_n     (rst_n),
        .take_i    (take),
        .tx_kind_i (tx_kind_i),
        .act_o     (act),
        .junk_o    (junk)
    );

    link_tx_mux u_tx_mux (
        .clk        (clk),
        .rst_n      (rst_n),
        .phy_rdy_i  (phy_rdy_i),
        .tx_req_i   (tx_req_i),
        .tx_kind_i  (tx_kind_i),
        .scr_dat_i  (scr_dat),
        .act_i      (act),
        .junk_i     (junk),
        .take_o     (take),
        .tx_ready_o (tx_ready_o),
        .tx_dat_o   (tx_dat_o),
        .tx_char_o  (tx_char_o)
    );

endmodule

// ==== link_tx_checker.sv ====
`timescale 1ns/10ps

module link_tx_checker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      phy_rdy_i,
    input  logic                      tx_req_i,
    input  sata_prim_pkg::prim_kind_t tx_kind_i,
    input  logic [31:0]               tx_dat_i,
    input  logic                      dut_ready_i,  // DUT tx_ready_o
    input  logic [31:0]               dut_dat_i,    // DUT tx_dat_o
    input  logic [3:0]                dut_char_i,   // DUT tx_char_o
    output int                        tests_o,
    output int                        failed_o,
    output int                        errors_o
);

    localparam logic [31:0] SEED    = 32'hC2D2_768D;
    localparam logic [31:0] POLY    = 32'h04C1_1DB7;
    localparam logic [31:0] ALIGN_W = 32'h7B4A_4ABC;
    localparam logic [31:0] CONT_W  = 32'h9999_AA7C;
    localparam logic [31:0] SYNC_W  = 32'hB5B5_957C;
    localparam int PASS_A = 0;
    localparam int CONT_A = 1;
    localparam int JUNK_A = 2;

    logic [7:0]                align_cnt;         // Model of the ALIGN counter
    logic [31:0]               scr_word;          // Data scrambler state
    logic [31:0]               junk_word;         // Junk generator state
    sata_prim_pkg::prim_kind_t last_kind;
    int                        run_pos;
    logic [31:0]               exp_dat;
    logic [3:0]                exp_char;
    logic                      took = 1'b0;       // Word on the wire comes from a take
    logic [31:0]               last_dat = 32'h0;  // DUT word of the latest take
    logic [3:0]                last_char = 4'h0;
    int                        n_tests = 0;
    int                        n_failed = 0;
    int                        n_errors = 0;
    int                        row_base = 0;      // Error count when the row started

    assign tests_o  = n_tests;
    assign failed_o = n_failed;
    assign errors_o = n_errors;

    function automatic logic [31:0] code_of(input sata_prim_pkg::prim_kind_t k);
        case (k)
            sata_prim_pkg::SOF:   return 32'h3737_B57C;
            sata_prim_pkg::EOF:   return 32'hD5D5_B57C;
            sata_prim_pkg::HOLD:  return 32'hD5D5_AA7C;
            sata_prim_pkg::HOLDA: return 32'h9595_AA7C;
            sata_prim_pkg::R_RDY: return 32'h4A4A_957C;
            sata_prim_pkg::X_RDY: return 32'h5757_B57C;
            sata_prim_pkg::WTRM:  return 32'h5858_B57C;
            sata_prim_pkg::R_IP:  return 32'h5555_B57C;
            sata_prim_pkg::R_OK:  return 32'h3535_B57C;
            sata_prim_pkg::R_ERR: return 32'h5656_B57C;
            sata_prim_pkg::DMAT:  return 32'h3636_B57C;
            sata_prim_pkg::SYNC:  return SYNC_W;
            default:              return 32'h0;  // Data kinds have no code
        endcase
    endfunction

    function automatic logic is_body(input sata_prim_pkg::prim_kind_t k);
        return (k == sata_prim_pkg::DATA) || (k == sata_prim_pkg::CRC);
    endfunction

    // Delimiters and DMAT never continue
    function automatic logic can_repeat(input sata_prim_pkg::prim_kind_t k);
        return !is_body(k) && (k != sata_prim_pkg::SOF) && (k != sata_prim_pkg::EOF)
            && (k != sata_prim_pkg::DMAT);
    endfunction

    // 32 serial Galois steps per word
    function automatic logic [31:0] lfsr_next(input logic [31:0] cur);
        logic [31:0] s;
        s = cur;
        for (int i = 0; i < 32; i++)
            s = s[31] ? ((s << 1) ^ POLY) : (s << 1);
        return s;
    endfunction

    function automatic logic in_pause(input logic [7:0] c);
        return (c == 8'd252) || (c == 8'd253);
    endfunction

    function automatic string act_name(input int a);
        case (a)
            PASS_A:  return "pass";
            CONT_A:  return "CONT";
            JUNK_A:  return "junk";
            default: return "none";
        endcase
    endfunction

    // Action that a DUT word shows on the wire
    function automatic int act_seen(input sata_prim_pkg::prim_kind_t k, input logic [31:0] d,
                                    input logic [3:0] c);
        if ((d == CONT_W) && (c == 4'h1))
            return CONT_A;
        if ((c == 4'h1) && (d == code_of(k)))
            return PASS_A;
        if ((c == 4'h0) && is_body(k))
            return PASS_A;                     // Scrambled payload
        if (c == 4'h0)
            return JUNK_A;
        return -1;
    endfunction

    // Expected word for the next cycle, from inputs sampled at the edge
    always @(posedge clk or negedge rst_n) begin : model
        logic take;
        int   run_new;
        int   act;
        if (!rst_n) begin
            align_cnt = 8'd0;
            scr_word  = SEED;
            junk_word = SEED;
            last_kind = sata_prim_pkg::DATA;   // Starts no run
            run_pos   = 0;
            exp_dat   = SYNC_W;
            exp_char  = 4'h1;
            took      = 1'b0;
        end else begin
            take = tx_req_i && phy_rdy_i && !in_pause(align_cnt);
            took = take;
            if (take) begin
                if (can_repeat(tx_kind_i) && (tx_kind_i == last_kind))
                    run_new = (run_pos >= 3) ? 3 : run_pos + 1;
                else
                    run_new = 1;
                if (run_new < 3)
                    act = PASS_A;
                else if (run_pos < 3)
                    act = CONT_A;              // First step into position 3
                else
                    act = JUNK_A;
                if (is_body(tx_kind_i)) begin
                    exp_dat  = tx_dat_i ^ scr_word;
                    exp_char = 4'h0;
                    scr_word = lfsr_next(scr_word);
                end else if (act == CONT_A) begin
                    exp_dat  = CONT_W;
                    exp_char = 4'h1;
                end else if (act == JUNK_A) begin
                    exp_dat   = junk_word;
                    exp_char  = 4'h0;
                    junk_word = lfsr_next(junk_word);
                end else begin
                    exp_dat  = code_of(tx_kind_i);
                    exp_char = 4'h1;
                end
                if (tx_kind_i == sata_prim_pkg::SOF)
                    scr_word = SEED;           // New frame
                run_pos   = run_new;
                last_kind = tx_kind_i;
            end else if (in_pause(align_cnt)) begin
                exp_dat  = ALIGN_W;
                exp_char = 4'h1;
            end else begin
                exp_dat  = SYNC_W;
                exp_char = 4'h1;
            end
            align_cnt = phy_rdy_i ? align_cnt + 8'd1 : 8'd0;
        end
    end

    // Outputs settle between edges
    always @(negedge clk) begin : compare
        logic exp_ready;
        exp_ready = phy_rdy_i && !in_pause(align_cnt);
        if (took) begin
            last_dat  = dut_dat_i;
            last_char = dut_char_i;
        end
        if (dut_dat_i !== exp_dat) begin
            $display("Mismatch tx_dat_o: expected %h, got %h at %0t", exp_dat, dut_dat_i, $time);
            n_errors++;
        end
        if (dut_char_i !== exp_char) begin
            $display("Mismatch tx_char_o: expected %h, got %h at %0t", exp_char, dut_char_i,
                     $time);
            n_errors++;
        end
        if (dut_ready_i !== exp_ready) begin
            $display("Mismatch tx_ready_o: expected %h, got %h at %0t", exp_ready, dut_ready_i,
                     $time);
            n_errors++;
            if (tx_req_i && dut_ready_i)
                $display("Request was taken while the link should hold it back");
            else if (tx_req_i)
                $display("Request was not taken although the link should accept it");
        end
    end

    // Called by the testbench once the row's last word has been compared
    task close_test(input string name, input int exp_act);
        logic act_ok;
        int   seen;
        seen   = act_seen(last_kind, last_dat, last_char);
        act_ok = (exp_act < 0) || (seen == exp_act);
        n_tests++;
        if (!act_ok)
            $display("Last word of %s was %s, expected %s", name, act_name(seen),
                     act_name(exp_act));
        if (act_ok && (n_errors == row_base)) begin
            $display("test %-12s ok", name);
        end else begin
            $display("test %-12s failed, %0d mismatches", name, n_errors - row_base);
            n_failed++;
        end
        row_base = n_errors;
    endtask

endmodule

// ==== tb_sata_link_tx.sv ====
`timescale 1ns/10ps

module tb_sata_link_tx;

    localparam int MAX_ROWS       = 24;
    localparam int ACT_NONE       = -1;
    localparam int ACT_PASS       = 0;
    localparam int ACT_CONT       = 1;
    localparam int ACT_JUNK       = 2;
    localparam int TIMEOUT_MARGIN = 600;   // Cycles on top of all repeats

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      phy_rdy;
    logic                      tx_req;
    sata_prim_pkg::prim_kind_t tx_kind;
    logic [31:0]               tx_dat;
    logic                      tx_ready;
    logic [31:0]               dut_dat;
    logic [3:0]                dut_char;
    int                        tests;
    int                        failed;
    int                        errors;
    integer                    seed = 4;
    logic [7:0]                rdy_cnt;          // Cycles since PHY ready, mod 256

    // Stimulus table
    string                     row_name [MAX_ROWS];
    sata_prim_pkg::prim_kind_t row_kind [MAX_ROWS];
    logic [31:0]               row_dat  [MAX_ROWS];  // Word of the first repeat
    int                        row_reps [MAX_ROWS];
    int                        row_act  [MAX_ROWS];  // Expected action of the last repeat
    bit                        row_sync [MAX_ROWS];  // Start just before an ALIGN pause
    int                        n_rows = 0;
    bit                        rows_loaded = 1'b0;

    always #2 clk = ~clk;

    sata_link_tx UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .phy_rdy_i  (phy_rdy),
        .tx_req_i   (tx_req),
        .tx_kind_i  (tx_kind),
        .tx_dat_i   (tx_dat),
        .tx_ready_o (tx_ready),
        .tx_dat_o   (dut_dat),
        .tx_char_o  (dut_char)
    );

    link_tx_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .phy_rdy_i   (phy_rdy),
        .tx_req_i    (tx_req),
        .tx_kind_i   (tx_kind),
        .tx_dat_i    (tx_dat),
        .dut_ready_i (tx_ready),
        .dut_dat_i   (dut_dat),
        .dut_char_i  (dut_char),
        .tests_o     (tests),
        .failed_o    (failed),
        .errors_o    (errors)
    );

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rdy_cnt <= 8'd0;
        else if (phy_rdy)
            rdy_cnt <= rdy_cnt + 8'd1;
        else
            rdy_cnt <= 8'd0;
    end

    task automatic add_row(input string name, input sata_prim_pkg::prim_kind_t kind,
                           input logic [31:0] dat, input int reps, input int act,
                           input bit sync);
        row_name[n_rows] = name;
        row_kind[n_rows] = kind;
        row_dat[n_rows]  = dat;
        row_reps[n_rows] = reps;
        row_act[n_rows]  = act;
        row_sync[n_rows] = sync;
        n_rows++;
    endtask

    task automatic load_table();
        add_row("sof_a",      sata_prim_pkg::SOF,   32'h0,         1,  ACT_PASS, 1'b0);
        add_row("data_a",     sata_prim_pkg::DATA,  32'h0000_0000, 5,  ACT_PASS, 1'b0);
        add_row("crc_a",      sata_prim_pkg::CRC,   32'h1234_5678, 1,  ACT_PASS, 1'b0);
        add_row("eof_a",      sata_prim_pkg::EOF,   32'h0,         1,  ACT_PASS, 1'b0);
        add_row("sof_b",      sata_prim_pkg::SOF,   32'h0,         1,  ACT_PASS, 1'b0);
        add_row("data_b",     sata_prim_pkg::DATA,  32'hFFFF_FFFF, 3,  ACT_PASS, 1'b0);
        add_row("crc_b",      sata_prim_pkg::CRC,   32'hA5A5_5A5A, 1,  ACT_PASS, 1'b0);
        add_row("eof_b",      sata_prim_pkg::EOF,   32'h0,         1,  ACT_PASS, 1'b0);
        add_row("hold_run",   sata_prim_pkg::HOLD,  32'h0,         6,  ACT_JUNK, 1'b0);
        add_row("r_ip",       sata_prim_pkg::R_IP,  32'h0,         1,  ACT_PASS, 1'b0);
        add_row("sof_rep",    sata_prim_pkg::SOF,   32'h0,         3,  ACT_PASS, 1'b0);
        add_row("eof_rep",    sata_prim_pkg::EOF,   32'h0,         3,  ACT_PASS, 1'b0);
        add_row("hold_alt",   sata_prim_pkg::HOLD,  32'h0,         1,  ACT_PASS, 1'b0);
        add_row("holda_alt",  sata_prim_pkg::HOLDA, 32'h0,         1,  ACT_PASS, 1'b0);
        add_row("hold_alt2",  sata_prim_pkg::HOLD,  32'h0,         1,  ACT_PASS, 1'b0);
        add_row("holda_alt2", sata_prim_pkg::HOLDA, 32'h0,         1,  ACT_PASS, 1'b0);
        add_row("hold_two",   sata_prim_pkg::HOLD,  32'h0,         2,  ACT_PASS, 1'b0);
        add_row("x_rdy_cont", sata_prim_pkg::X_RDY, 32'h0,         3,  ACT_CONT, 1'b0);
        add_row("pause_hold", sata_prim_pkg::HOLD,  32'h0,         12, ACT_JUNK, 1'b1);
        add_row("r_ok",       sata_prim_pkg::R_OK,  32'h0,         1,  ACT_PASS, 1'b0);
    endtask

    function automatic int total_repeats();
        int sum;
        sum = 0;
        for (int i = 0; i < n_rows; i++)
            sum += row_reps[i];
        return sum;
    endfunction

    // Hold one request until the DUT takes it
    task automatic send_request(input sata_prim_pkg::prim_kind_t kind, input logic [31:0] dat);
        bit taken;
        tx_req  = 1'b1;
        tx_kind = kind;
        tx_dat  = dat;
        taken   = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = tx_ready;                // Take happens at the coming edge
            @(posedge clk);
            #1;
        end
    endtask

    // Four takes before the pause slots at 252 and 253
    task automatic wait_pause_window();
        while (rdy_cnt != 8'd248) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_row(input int i);
        logic [31:0] word;
        if (row_sync[i])
            wait_pause_window();
        for (int r = 0; r < row_reps[i]; r++) begin
            word = (r == 0) ? row_dat[i] : $random(seed);
            send_request(row_kind[i], word);
        end
        tx_req = 1'b0;
        @(posedge clk);                      // Last word compared in between
        #1;
        u_checker.close_test(row_name[i], row_act[i]);
    endtask

    initial begin
        rst_n   = 1'b0;
        phy_rdy = 1'b0;
        tx_req  = 1'b0;
        tx_kind = sata_prim_pkg::SYNC;
        tx_dat  = 32'h0;
        load_table();
        rows_loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) begin                     // Idle with PHY down
            @(posedge clk);
            #1;
        end
        u_checker.close_test("reset_idle", ACT_NONE);
        phy_rdy = 1'b1;
        for (int i = 0; i < n_rows; i++)
            run_row(i);
        repeat (2) @(posedge clk);
        #1;
        $display("Summary: %0d tests, %0d failed, %0d mismatches", tests, failed, errors);
        if ((failed == 0) && (errors == 0))
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (rows_loaded);
        limit = total_repeats() + TIMEOUT_MARGIN;
        repeat (limit) @(posedge clk);
        $display("Timeout: run still busy after %0d clock cycles", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== verilog.f ====
sata_prim_pkg.sv
sata_link_pkg.sv
scrambler_lfsr.sv
data_scrambler.sv
prim_repeat_tracker.sv
link_tx_mux.sv
sata_link_tx.sv
link_tx_checker.sv
tb_sata_link_tx.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_sata_link_tx
FILELIST = verilog.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
